// ==== src/snake_pkg.sv ====
package snake_pkg;

	// playfield in grid cells
	localparam int GRID_W = 160;
	localparam int GRID_H = 120;

	// border thickness, the bottom edge sits one row higher
	localparam int WALL = 2;

	// body capacity and starting length
	localparam int MAX_LEN = 64;
	localparam int IDX_W   = $clog2(MAX_LEN);

	// segment count, needs to hold MAX_LEN itself
	typedef logic [$clog2(MAX_LEN + 1)-1:0] len_t;

	localparam len_t INIT_LEN = 5;

	// start head, body trails off to the right
	localparam logic [7:0] INIT_HEAD_X = 8'd30;
	localparam logic [6:0] INIT_HEAD_Y = 7'd20;

	// cycles spent in the pacing delay before each move
	localparam int STEP_TICKS = 16;
	localparam int DLY_W      = $clog2(STEP_TICKS);
	localparam logic [DLY_W-1:0] PACE_LAST = DLY_W'(STEP_TICKS - 1);

	// apple random register start value, must not be zero
	localparam logic [14:0] LFSR_SEED = 15'h1ACE;

	// one grid cell
	typedef struct packed {
		logic [7:0] x;
		logic [6:0] y;
	} cell_t;

	// reverse of a heading is the heading with bit 0 flipped
	typedef enum logic [1:0] {
		LEFT  = 2'b00,
		RIGHT = 2'b01,
		DOWN  = 2'b10,
		UP    = 2'b11
	} dir_t;

	// pressed button reads 1
	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic up;
	} buttons_t;

	typedef struct packed {
		cell_t head;
		cell_t apple;
		len_t  length;
		logic  game_over;
	} game_status_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_LOAD, ST_APPLE, ST_DELAY, ST_MOVE, ST_EAT, ST_SCAN, ST_DEAD
	} state_t;

endpackage

// ==== src/steer_ctrl.sv ====
`timescale 1ns/100ps

module steer_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load,
	input  logic                move,
	input  snake_pkg::buttons_t btn,
	output snake_pkg::dir_t     heading
);
	// presses collected since the last move
	snake_pkg::buttons_t pend;
	snake_pkg::buttons_t req;
	snake_pkg::dir_t     want;
	logic                want_vld;
	logic                take;

	// a press in the move cycle itself counts too
	assign req = snake_pkg::buttons_t'(pend | btn);

	// priority left, right, down, up
	always_comb begin
		want_vld = 1'b1;
		if (req.left)
			want = snake_pkg::LEFT;
		else if (req.right)
			want = snake_pkg::RIGHT;
		else if (req.down)
			want = snake_pkg::DOWN;
		else if (req.up)
			want = snake_pkg::UP;
		else begin
			want     = heading;
			want_vld = 1'b0;
		end
	end

	// reversal straight back is dropped, no fallback to a lower press
	assign take = want_vld && (want != snake_pkg::dir_t'(heading ^ 2'b01));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			heading <= snake_pkg::LEFT;
			pend    <= '0;
		end else if (load) begin
			heading <= snake_pkg::LEFT;
			pend    <= '0;
		end else if (move) begin
			// new heading is used from the following move on
			if (take)
				heading <= want;
			pend <= '0;
		end else begin
			pend <= req;
		end
	end

endmodule

// ==== src/snake_body.sv ====
`timescale 1ns/100ps

module snake_body (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             move,
	input  logic             grow,
	input  logic             scan_en,
	input  snake_pkg::dir_t  heading,
	output snake_pkg::cell_t head,
	output snake_pkg::len_t  length,
	output logic             collision,
	output logic             scan_done
);
	// segment 0 is the head, tail sits at length-1
	snake_pkg::cell_t segs [snake_pkg::MAX_LEN];
	snake_pkg::cell_t head_nxt;
	snake_pkg::cell_t seg_at;

	// scan walk position, runs 0..length
	snake_pkg::len_t idx;
	logic hit_q;
	logic seg_hit;
	logic in_wall;

	assign head = segs[0];

	// one cell along the heading
	always_comb begin
		head_nxt = segs[0];
		case (heading)
			snake_pkg::LEFT:  head_nxt.x = segs[0].x - 1'b1;
			snake_pkg::RIGHT: head_nxt.x = segs[0].x + 1'b1;
			snake_pkg::DOWN:  head_nxt.y = segs[0].y + 1'b1;
			default:          head_nxt.y = segs[0].y - 1'b1;
		endcase
	end

	// shift chain, old tail lands at index length so a grow keeps it
	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
				segs[i].x <= 8'(snake_pkg::INIT_HEAD_X + i);
				segs[i].y <= snake_pkg::INIT_HEAD_Y;
			end
		end else if (move) begin
			for (int i = snake_pkg::MAX_LEN - 1; i > 0; i--)
				segs[i] <= segs[i-1];
			segs[0] <= head_nxt;
		end
	end

	assign seg_at = segs[idx[snake_pkg::IDX_W-1:0]];

	// head itself at idx 0 is skipped
	assign seg_hit = scan_en && (idx != '0) && (idx < length) && (seg_at == segs[0]);

	// left and top edges below WALL, bottom row limit one tighter
	assign in_wall = (segs[0].x < snake_pkg::WALL) ||
		(segs[0].x > snake_pkg::GRID_W - snake_pkg::WALL) ||
		(segs[0].y < snake_pkg::WALL) ||
		(segs[0].y > snake_pkg::GRID_H - 3);

	// last walk step is the wall check
	assign scan_done = scan_en && (idx == length);
	assign collision = hit_q || (scan_done && in_wall);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			length <= snake_pkg::INIT_LEN;
			idx    <= '0;
			hit_q  <= 1'b0;
		end else begin
			if (load)
				length <= snake_pkg::INIT_LEN;
			else if (grow && length < snake_pkg::MAX_LEN)
				length <= length + 1'b1;
			// fresh walk for every move
			if (load || move) begin
				idx   <= '0;
				hit_q <= 1'b0;
			end else if (scan_en && !scan_done) begin
				idx <= idx + 1'b1;
				if (seg_hit)
					hit_q <= 1'b1;
			end
		end
	end

endmodule

// ==== src/apple_gen.sv ====
`timescale 1ns/100ps

module apple_gen (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             make_apple,
	input  snake_pkg::cell_t head,
	output snake_pkg::cell_t apple,
	output logic             eaten
);
	// 15-bit fibonacci register
	logic [14:0] lfsr;
	// value after one step, used for placement
	logic [14:0] r;
	logic [7:0]  x_raw;
	logic [6:0]  y_raw;
	snake_pkg::cell_t place;

	// shift left, feedback from the two top taps
	assign r = {lfsr[13:0], lfsr[14] ^ lfsr[13]};

	assign x_raw = r[7:0];
	assign y_raw = r[14:8];

	// fold the raw values back inside the walls
	always_comb begin
		if (x_raw >= 8'd150)
			place.x = x_raw - 8'd110;
		else
			place.x = x_raw + 8'd3;
		if (y_raw >= 7'd100)
			place.y = y_raw - 7'd98;
		else
			place.y = y_raw + 7'd2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lfsr <= snake_pkg::LFSR_SEED;
		else if (load)
			lfsr <= snake_pkg::LFSR_SEED;
		else if (make_apple)
			lfsr <= r;
	end

	// apple cell follows the register step
	always_ff @(posedge clk) begin
		if (make_apple)
			apple <= place;
	end

	assign eaten = (head == apple);

endmodule

// ==== src/game_fsm.sv ====
`timescale 1ns/100ps

module game_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic eaten,
	input  logic collision,
	input  logic scan_done,
	output logic load,
	output logic make_apple,
	output logic move,
	output logic grow,
	output logic scan_en,
	output logic step_valid,
	output logic game_over
);
	snake_pkg::state_t state;
	snake_pkg::state_t state_nxt;

	// pacing delay between moves
	logic [snake_pkg::DLY_W-1:0] pace_cnt;
	logic pace_done;

	// last scan cycle of a move that hit something
	logic dead_set;
	logic step_end;

	assign pace_done = (pace_cnt == snake_pkg::PACE_LAST);
	assign step_end  = (state == snake_pkg::ST_SCAN) && scan_done;
	assign dead_set  = step_end && collision;

	always_comb begin
		state_nxt = state;
		case (state)
			snake_pkg::ST_IDLE: begin
				if (start)
					state_nxt = snake_pkg::ST_LOAD;
			end
			snake_pkg::ST_LOAD:  state_nxt = snake_pkg::ST_APPLE;
			snake_pkg::ST_APPLE: state_nxt = snake_pkg::ST_DELAY;
			snake_pkg::ST_DELAY: begin
				if (pace_done)
					state_nxt = snake_pkg::ST_MOVE;
			end
			// eat test sees the new head one cycle after the move
			snake_pkg::ST_MOVE: state_nxt = snake_pkg::ST_EAT;
			snake_pkg::ST_EAT:  state_nxt = snake_pkg::ST_SCAN;
			snake_pkg::ST_SCAN: begin
				if (scan_done)
					state_nxt = collision ? snake_pkg::ST_DEAD : snake_pkg::ST_DELAY;
			end
			// game over holds until the next start
			snake_pkg::ST_DEAD: begin
				if (start)
					state_nxt = snake_pkg::ST_LOAD;
			end
			default: state_nxt = snake_pkg::ST_IDLE;
		endcase
	end

	// command pulses, decoded straight from the state
	assign load       = (state == snake_pkg::ST_LOAD);
	assign move       = (state == snake_pkg::ST_MOVE);
	assign scan_en    = (state == snake_pkg::ST_SCAN);
	assign grow       = (state == snake_pkg::ST_EAT) && eaten;
	// fresh apple on the first frame and after every eat
	assign make_apple = (state == snake_pkg::ST_APPLE) || grow;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= snake_pkg::ST_IDLE;
			pace_cnt   <= '0;
			step_valid <= 1'b0;
			game_over  <= 1'b0;
		end else begin
			state <= state_nxt;
			// counter only runs inside the delay state
			if (state == snake_pkg::ST_DELAY)
				pace_cnt <= pace_cnt + 1'b1;
			else
				pace_cnt <= '0;
			// end of move, status already holds the result
			step_valid <= step_end;
			if (load)
				game_over <= 1'b0;
			else if (dead_set)
				game_over <= 1'b1;
		end
	end

endmodule

// ==== src/snake_top.sv ====
`timescale 1ns/100ps

module snake_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  snake_pkg::buttons_t    btn,
	output snake_pkg::game_status_t status,
	output logic                   step_valid
);
	// one-cycle commands from the FSM
	logic load;
	logic make_apple;
	logic move;
	logic grow;
	logic scan_en;

	// flags back to the FSM
	logic eaten;
	logic collision;
	logic scan_done;
	logic game_over;

	snake_pkg::dir_t  heading;
	snake_pkg::cell_t head;
	snake_pkg::cell_t apple;
	snake_pkg::len_t  length;

	game_fsm u_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.eaten      (eaten),
		.collision  (collision),
		.scan_done  (scan_done),
		.load       (load),
		.make_apple (make_apple),
		.move       (move),
		.grow       (grow),
		.scan_en    (scan_en),
		.step_valid (step_valid),
		.game_over  (game_over)
	);

	steer_ctrl u_steer (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.move    (move),
		.btn     (btn),
		.heading (heading)
	);

	snake_body u_body (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (load),
		.move      (move),
		.grow      (grow),
		.scan_en   (scan_en),
		.heading   (heading),
		.head      (head),
		.length    (length),
		.collision (collision),
		.scan_done (scan_done)
	);

	apple_gen u_apple (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.make_apple (make_apple),
		.head       (head),
		.apple      (apple),
		.eaten      (eaten)
	);

	// status seen by the outside, valid when step_valid pulses
	assign status = '{head: head, apple: apple, length: length, game_over: game_over};

endmodule

// ==== tb/snake_assert.sv ====
`timescale 1ns/100ps

module snake_assert (
	input logic              clk,
	input logic              rst_n,
	input snake_pkg::state_t state,
	input logic              load,
	input logic              move,
	input logic              grow,
	input logic              step_valid,
	input logic              game_over,
	input snake_pkg::len_t   length
);
	// failures so far, the testbench reads this at the end
	int fail_cnt = 0;

	// status pulse lasts one cycle
	a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		step_valid |=> !step_valid) else begin
		fail_cnt++;
		$error("step_valid longer than one cycle");
	end

	// no move result once the game is over
	a_dead: assert property (@(posedge clk) disable iff (!rst_n)
		game_over |=> !step_valid) else begin
		fail_cnt++;
		$error("step_valid while game_over is high");
	end

	// length changes only on a load or a grow, never past capacity
	a_len: assert property (@(posedge clk) disable iff (!rst_n)
		length <= snake_pkg::MAX_LEN &&
		(length == $past(length) || $past(load) || $past(grow))) else begin
		fail_cnt++;
		$error("length above MAX_LEN or changed without load or grow");
	end

	// move command only from the move state, entered straight from the delay
	a_move: assert property (@(posedge clk) disable iff (!rst_n)
		move |-> state == snake_pkg::ST_MOVE && $past(state) == snake_pkg::ST_DELAY) else begin
		fail_cnt++;
		$error("move outside the move state or not right after the pacing delay");
	end

endmodule

// FSM state through u_fsm, length and commands from the top level wires
bind snake_top snake_assert u_chk (.*, .state(u_fsm.state));

// ==== tb/snake_tb.sv ====
`timescale 1ns/100ps

module snake_tb;
	// one table row, expected length and game_over hold at its last move
	typedef struct packed {
		logic [3:0] btn;
		logic       start;
		logic [7:0] moves;
		logic [6:0] exp_len;
		logic       exp_over;
	} row_t;

	localparam int N_ROWS   = 13;
	localparam int STEP_MAX = snake_pkg::STEP_TICKS + snake_pkg::MAX_LEN + 4;
	localparam int PRESS    = 4;

	// btn bits are left, right, down, up
	localparam row_t ROWS [N_ROWS] = '{
		'{4'b0000, 1'b1, 8'd3, 7'd5, 1'b0},
		// right is a reversal, then up, then right along y 19
		'{4'b0100, 1'b0, 8'd1, 7'd5, 1'b0},
		'{4'b0001, 1'b0, 8'd1, 7'd5, 1'b0},
		'{4'b0100, 1'b0, 8'd1, 7'd5, 1'b0},
		'{4'b0000, 1'b0, 8'd20, 7'd5, 1'b0},
		// down at x 46, first apple sits at 46,55
		'{4'b0010, 1'b0, 8'd1, 7'd5, 1'b0},
		'{4'b0000, 1'b0, 8'd36, 7'd6, 1'b0},
		// left along y 56 into the wall
		'{4'b1000, 1'b0, 8'd1, 7'd6, 1'b0},
		'{4'b0000, 1'b0, 8'd45, 7'd6, 1'b1},
		// second game, loop back onto its own body
		'{4'b0010, 1'b1, 8'd1, 7'd5, 1'b0},
		'{4'b0100, 1'b0, 8'd1, 7'd5, 1'b0},
		'{4'b0001, 1'b0, 8'd1, 7'd5, 1'b0},
		'{4'b0000, 1'b0, 8'd1, 7'd5, 1'b1}
	};

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	logic step_valid;
	snake_pkg::buttons_t     btn;
	snake_pkg::game_status_t status;

	// reference game, head at body[0]
	snake_pkg::cell_t body [$];
	snake_pkg::cell_t m_apple;
	snake_pkg::dir_t  m_dir;
	logic [14:0]      m_lfsr;
	int               m_apples;
	logic             m_over;
	int               seed = 77;

	snake_top DUT (.clk(clk), .rst_n(rst_n), .start(start), .btn(btn),
		.status(status), .step_valid(step_valid));

	always #2 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	// next register value, apple folded inside the walls
	task automatic place_apple();
		int rx;
		int ry;
		m_lfsr = 15'({m_lfsr, m_lfsr[14] ^ m_lfsr[13]});
		rx = m_lfsr % 256;
		ry = m_lfsr / 256;
		m_apple.x = 8'(rx >= 150 ? rx - 110 : rx + 3);
		m_apple.y = 7'(ry >= 100 ? ry - 98 : ry + 2);
		m_apples++;
	endtask

	task automatic new_game();
		body.delete();
		for (int i = 0; i < snake_pkg::INIT_LEN; i++)
			body.push_back(snake_pkg::cell_t'{x: 8'(snake_pkg::INIT_HEAD_X + i),
				y: snake_pkg::INIT_HEAD_Y});
		m_dir = snake_pkg::LEFT;
		m_lfsr = snake_pkg::LFSR_SEED;
		m_apples = 0;
		m_over = 1'b0;
		place_apple();
	endtask

	task automatic model_step(input logic [3:0] b);
		snake_pkg::cell_t h;
		snake_pkg::dir_t  want;
		logic             same_axis;
		h = body[0];
		case (m_dir)
			snake_pkg::LEFT:  h.x = h.x - 1;
			snake_pkg::RIGHT: h.x = h.x + 1;
			snake_pkg::DOWN:  h.y = h.y + 1;
			default:          h.y = h.y - 1;
		endcase
		body.push_front(h);
		// eating keeps the tail and draws the next apple
		if (h == m_apple)
			place_apple();
		else
			void'(body.pop_back());
		for (int i = 1; i < body.size(); i++)
			if (body[i] == h)
				m_over = 1'b1;
		if (h.x < snake_pkg::WALL || h.x > snake_pkg::GRID_W - snake_pkg::WALL ||
			h.y < snake_pkg::WALL || h.y > snake_pkg::GRID_H - 3)
			m_over = 1'b1;
		// turn takes effect on the next move
		want = b[3] ? snake_pkg::LEFT : b[2] ? snake_pkg::RIGHT :
			b[1] ? snake_pkg::DOWN : snake_pkg::UP;
		same_axis = (m_dir inside {snake_pkg::LEFT, snake_pkg::RIGHT}) ==
			(want inside {snake_pkg::LEFT, snake_pkg::RIGHT});
		if (b != 4'b0000 && !(same_axis && want != m_dir))
			m_dir = want;
	endtask

	task automatic check_status();
		assert (status.head == body[0]) else
			stop_run($sformatf("Error at %0t: head %0d,%0d, expected %0d,%0d", $time,
				status.head.x, status.head.y, body[0].x, body[0].y));
		assert (status.apple == m_apple) else
			stop_run($sformatf("Error at %0t: apple %0d,%0d, expected apple %0d at %0d,%0d",
				$time, status.apple.x, status.apple.y, m_apples, m_apple.x, m_apple.y));
		assert (status.length == body.size()) else
			stop_run($sformatf("Error at %0t: length %0d, expected %0d", $time,
				status.length, body.size()));
		assert (status.game_over == m_over) else
			stop_run($sformatf("Error at %0t: game_over %0b, expected %0b", $time,
				status.game_over, m_over));
	endtask

	// short press inside the pacing delay, then wait for the end of the move
	task automatic run_step(input logic [3:0] b, input logic go);
		int n;
		btn = snake_pkg::buttons_t'(b);
		start = go;
		for (n = 0; n < PRESS; n++) begin
			@(negedge clk);
			start = 1'b0;
			assert (!step_valid) else stop_run("step_valid came during a button press");
		end
		btn = '0;
		n = 0;
		while (!step_valid) begin
			assert (n < STEP_MAX) else stop_run("Timeout while waiting for step_valid");
			n++;
			@(negedge clk);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		btn = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// button noise while idle
		repeat (20) begin
			@(negedge clk);
			btn = snake_pkg::buttons_t'(4'($random(seed)));
			assert (!step_valid && !status.game_over) else
				stop_run("step_valid or game_over went high before start");
		end
		for (int r = 0; r < N_ROWS; r++) begin
			for (int m = 0; m < ROWS[r].moves; m++) begin
				if (ROWS[r].start && m == 0)
					new_game();
				run_step(ROWS[r].btn, ROWS[r].start && m == 0);
				model_step(ROWS[r].btn);
				check_status();
				// dead game stays silent
				if (m_over)
					repeat (STEP_MAX) begin
						@(negedge clk);
						assert (!step_valid) else stop_run("step_valid came after game over");
					end
			end
			assert (status.length == ROWS[r].exp_len && status.game_over == ROWS[r].exp_over)
				else stop_run($sformatf("Error at %0t: row %0d ended at length %0d game_over %0b",
				$time, r, status.length, status.game_over));
		end
		if (DUT.u_chk.fail_cnt != 0)
			stop_run("Concurrent assertions in the game FSM failed");
		else begin
			$display("Regression passed");
			$finish;
		end
	end

	// watchdog, sized from the table
	initial begin
		int moves;
		moves = 0;
		for (int i = 0; i < N_ROWS; i++)
			moves += ROWS[i].moves;
		repeat (moves * STEP_MAX + 1000) @(posedge clk);
		stop_run("Watchdog expired before all moves were done");
	end

endmodule

// ==== tb.f ====
src/snake_pkg.sv
src/steer_ctrl.sv
src/snake_body.sv
src/apple_gen.sv
src/game_fsm.sv
src/snake_top.sv
tb/snake_assert.sv
tb/snake_tb.sv

// ==== Bender.yml ====
package:
  name: snake

sources:
  - src/snake_pkg.sv
  - src/steer_ctrl.sv
  - src/snake_body.sv
  - src/apple_gen.sv
  - src/game_fsm.sv
  - src/snake_top.sv
  - target: test
    files:
      - tb/snake_assert.sv
      - tb/snake_tb.sv
